//--- rtl/pe_ctrl_pkg.sv
// PE array control package
// shared widths, APB register map, command bits, burst constants and FSM states
package pe_ctrl_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0]  act_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  dim_t;
  typedef logic [7:0]  count_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_ISSUE,
    FETCH_WAIT,
    FETCH_NEXT
  } fetch_state_t;

  typedef enum logic [1:0] {
    FEED_IDLE,
    FEED_WEIGHTS,
    FEED_RUN
  } feed_state_t;

  // operand buffers
  localparam int NUM_BUFS   = 3;
  localparam int BUF_WEIGHT = 0;
  localparam int BUF_INPUT  = 1;
  localparam int BUF_PSUM   = 2;
  localparam int BUF_DEPTH  = 64;
  localparam int BUF_PTR_W  = 6;

  // memory read bursts
  localparam int BYTES_PER_WORD = 4;
  localparam int BURST_LEN      = 16;
  localparam int BURST_BYTES    = BURST_LEN * BYTES_PER_WORD;
  localparam int WEIGHT_BURSTS  = 1;
  localparam int INPUT_BURSTS   = 2;
  localparam int PSUM_BURSTS    = 3;

  // APB register offsets
  localparam addr_t REG_ACC_PARAMS  = 32'h00;
  localparam addr_t REG_MEM_CTRL    = 32'h04;
  localparam addr_t REG_WEIGHT_BASE = 32'h08;
  localparam addr_t REG_INPUT_BASE  = 32'h0C;
  localparam addr_t REG_PSUM_BASE   = 32'h10;
  localparam addr_t REG_STATUS      = 32'h14;

  // MEM_CTRL command bits
  localparam int CMD_FETCH_WEIGHTS = 0;
  localparam int CMD_FETCH_INPUTS  = 1;
  localparam int CMD_FETCH_PSUMS   = 2;
  localparam int CMD_CLEAR_WEIGHTS = 3;
  localparam int CMD_CLEAR_INPUTS  = 4;
  localparam int CMD_CLEAR_PSUMS   = 5;
  localparam int CMD_START         = 6;
  localparam int CMD_LOAD_WEIGHTS  = 7;

  // STATUS fields, buffered and error flags indexed by buffer
  localparam int STAT_BUFFERED = 0;
  localparam int STAT_RUNNING  = 3;
  localparam int STAT_ERROR    = 4;

endpackage

//--- rtl/pe_ctrl_regs.sv
// APB register file for the PE array control unit
// holds parameters and base addresses, turns MEM_CTRL writes into command pulses
`timescale 1ns/100ps

module pe_ctrl_regs (
  input  logic                               CLK,
  input  logic                               RESETN,
  input  pe_ctrl_pkg::addr_t                 paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  pe_ctrl_pkg::word_t                 pwdata,
  input  pe_ctrl_pkg::word_t                 status,
  output pe_ctrl_pkg::word_t                 prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic [pe_ctrl_pkg::NUM_BUFS-1:0]   fetch_cmd,
  output logic [pe_ctrl_pkg::NUM_BUFS-1:0]   clear_cmd,
  output logic                               start_cmd,
  output logic                               load_cmd,
  output pe_ctrl_pkg::addr_t                 weight_base,
  output pe_ctrl_pkg::addr_t                 input_base,
  output pe_ctrl_pkg::addr_t                 psum_base,
  output pe_ctrl_pkg::dim_t                  param_r,
  output pe_ctrl_pkg::dim_t                  tile_size
);

  logic       access;
  logic       wr_en;
  logic       addr_hit;
  logic [7:0] cmd_q;

  assign access = psel && penable;
  assign wr_en  = access && pwrite;
  assign pready = 1'b1;

  // read mux, MEM_CTRL reads back as zero
  always_comb begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      pe_ctrl_pkg::REG_ACC_PARAMS:  prdata = pe_ctrl_pkg::word_t'({tile_size, param_r});
      pe_ctrl_pkg::REG_MEM_CTRL:    prdata = '0;
      pe_ctrl_pkg::REG_WEIGHT_BASE: prdata = weight_base;
      pe_ctrl_pkg::REG_INPUT_BASE:  prdata = input_base;
      pe_ctrl_pkg::REG_PSUM_BASE:   prdata = psum_base;
      pe_ctrl_pkg::REG_STATUS:      prdata = status;
      default:                      addr_hit = 1'b0;
    endcase
  end

  assign pslverr = access && !addr_hit;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      param_r     <= '0;
      tile_size   <= '0;
      weight_base <= '0;
      input_base  <= '0;
      psum_base   <= '0;
      cmd_q       <= '0;
    end else begin
      // commands live for one cycle only
      cmd_q <= '0;
      if (wr_en) begin
        case (paddr)
          pe_ctrl_pkg::REG_ACC_PARAMS: begin
            param_r   <= pwdata[3:0];
            tile_size <= pwdata[7:4];
          end
          pe_ctrl_pkg::REG_MEM_CTRL:    cmd_q       <= pwdata[7:0];
          pe_ctrl_pkg::REG_WEIGHT_BASE: weight_base <= pwdata;
          pe_ctrl_pkg::REG_INPUT_BASE:  input_base  <= pwdata;
          pe_ctrl_pkg::REG_PSUM_BASE:   psum_base   <= pwdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    fetch_cmd[pe_ctrl_pkg::BUF_WEIGHT] = cmd_q[pe_ctrl_pkg::CMD_FETCH_WEIGHTS];
    fetch_cmd[pe_ctrl_pkg::BUF_INPUT]  = cmd_q[pe_ctrl_pkg::CMD_FETCH_INPUTS];
    fetch_cmd[pe_ctrl_pkg::BUF_PSUM]   = cmd_q[pe_ctrl_pkg::CMD_FETCH_PSUMS];
    clear_cmd[pe_ctrl_pkg::BUF_WEIGHT] = cmd_q[pe_ctrl_pkg::CMD_CLEAR_WEIGHTS];
    clear_cmd[pe_ctrl_pkg::BUF_INPUT]  = cmd_q[pe_ctrl_pkg::CMD_CLEAR_INPUTS];
    clear_cmd[pe_ctrl_pkg::BUF_PSUM]   = cmd_q[pe_ctrl_pkg::CMD_CLEAR_PSUMS];
    start_cmd = cmd_q[pe_ctrl_pkg::CMD_START];
    load_cmd  = cmd_q[pe_ctrl_pkg::CMD_LOAD_WEIGHTS];
  end

  // an error response only comes in the access phase of a proper transfer
  assert property (@(posedge CLK) disable iff (!RESETN)
    pslverr |-> $past(psel && !penable));

endmodule

//--- rtl/burst_fetcher.sv
// Read burst sequencer
// walks pending fetch requests in order and fills the operand buffers
`timescale 1ns/100ps

module burst_fetcher (
  input  logic                             CLK,
  input  logic                             RESETN,
  input  logic [pe_ctrl_pkg::NUM_BUFS-1:0] fetch_cmd,
  input  pe_ctrl_pkg::addr_t               weight_base,
  input  pe_ctrl_pkg::addr_t               input_base,
  input  pe_ctrl_pkg::addr_t               psum_base,
  input  logic [pe_ctrl_pkg::NUM_BUFS-1:0] buf_full,
  input  logic                             rd_beat_valid,
  input  pe_ctrl_pkg::word_t               rd_data,
  input  logic                             rd_done,
  input  logic                             rd_error,
  output logic                             rd_start,
  output pe_ctrl_pkg::addr_t               rd_addr,
  output logic [pe_ctrl_pkg::NUM_BUFS-1:0] push,
  output pe_ctrl_pkg::word_t               push_data,
  output logic [pe_ctrl_pkg::NUM_BUFS-1:0] buffered,
  output logic [pe_ctrl_pkg::NUM_BUFS-1:0] fetch_error
);

  pe_ctrl_pkg::fetch_state_t        state;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] pending;
  logic [1:0]                       sel;
  logic [1:0]                       next_sel;
  logic [1:0]                       burst_cnt;
  logic [1:0]                       last_burst;
  pe_ctrl_pkg::addr_t               next_base;
  logic                             beat;

  // weights first, then inputs, then psums
  always_comb begin
    if (pending[pe_ctrl_pkg::BUF_WEIGHT]) begin
      next_sel  = 2'(pe_ctrl_pkg::BUF_WEIGHT);
      next_base = weight_base;
    end else if (pending[pe_ctrl_pkg::BUF_INPUT]) begin
      next_sel  = 2'(pe_ctrl_pkg::BUF_INPUT);
      next_base = input_base;
    end else begin
      next_sel  = 2'(pe_ctrl_pkg::BUF_PSUM);
      next_base = psum_base;
    end
  end

  always_comb begin
    case (sel)
      2'(pe_ctrl_pkg::BUF_WEIGHT): last_burst = 2'(pe_ctrl_pkg::WEIGHT_BURSTS - 1);
      2'(pe_ctrl_pkg::BUF_INPUT):  last_burst = 2'(pe_ctrl_pkg::INPUT_BURSTS - 1);
      default:                     last_burst = 2'(pe_ctrl_pkg::PSUM_BURSTS - 1);
    endcase
  end

  assign rd_start  = (state == pe_ctrl_pkg::FETCH_ISSUE);
  assign beat      = (state == pe_ctrl_pkg::FETCH_WAIT) && rd_beat_valid;
  assign push_data = rd_data;

  // a beat into a full buffer is dropped here
  always_comb begin
    push      = '0;
    push[sel] = beat && !buf_full[sel];
  end

  always_ff @(posedge CLK) begin
    if (state == pe_ctrl_pkg::FETCH_IDLE) begin
      rd_addr <= next_base;
    end else if (state == pe_ctrl_pkg::FETCH_NEXT) begin
      rd_addr <= rd_addr + pe_ctrl_pkg::addr_t'(pe_ctrl_pkg::BURST_BYTES);
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state       <= pe_ctrl_pkg::FETCH_IDLE;
      pending     <= '0;
      sel         <= '0;
      burst_cnt   <= '0;
      buffered    <= '0;
      fetch_error <= '0;
    end else begin
      case (state)
        pe_ctrl_pkg::FETCH_IDLE: begin
          if (|pending) begin
            sel       <= next_sel;
            burst_cnt <= '0;
            state     <= pe_ctrl_pkg::FETCH_ISSUE;
          end
        end
        pe_ctrl_pkg::FETCH_ISSUE: state <= pe_ctrl_pkg::FETCH_WAIT;
        pe_ctrl_pkg::FETCH_WAIT: begin
          if (beat && buf_full[sel]) begin
            fetch_error[sel] <= 1'b1;
          end
          if (rd_done) begin
            if (rd_error) begin
              fetch_error[sel] <= 1'b1;
            end
            // last burst done, flag visible next cycle
            if (burst_cnt == last_burst) begin
              buffered[sel] <= 1'b1;
              pending[sel]  <= 1'b0;
            end
            state <= pe_ctrl_pkg::FETCH_NEXT;
          end
        end
        default: begin
          if (burst_cnt == last_burst) begin
            state <= pe_ctrl_pkg::FETCH_IDLE;
          end else begin
            burst_cnt <= burst_cnt + 1'b1;
            state     <= pe_ctrl_pkg::FETCH_ISSUE;
          end
        end
      endcase
      // a new request restarts that buffer's flags
      for (int i = 0; i < pe_ctrl_pkg::NUM_BUFS; i++) begin
        if (fetch_cmd[i]) begin
          pending[i]     <= 1'b1;
          buffered[i]    <= 1'b0;
          fetch_error[i] <= 1'b0;
        end
      end
    end
  end

  // one burst outstanding, so the memory is quiet when a new one starts
  assert property (@(posedge CLK) disable iff (!RESETN)
    rd_start |-> !rd_beat_valid && !rd_done);

  // beats and done only answer an issued burst
  assert property (@(posedge CLK) disable iff (!RESETN)
    (rd_beat_valid || rd_done) |-> state == pe_ctrl_pkg::FETCH_WAIT);

endmodule

//--- rtl/operand_buffer.sv
// Operand buffer
// first word fall-through FIFO with a one-cycle clear
`timescale 1ns/100ps

module operand_buffer (
  input  logic               CLK,
  input  logic               RESETN,
  input  logic               clear,
  input  logic               push,
  input  pe_ctrl_pkg::word_t push_data,
  input  logic               pop,
  output pe_ctrl_pkg::word_t pop_data,
  output logic               empty,
  output logic               full
);

  pe_ctrl_pkg::word_t                 mem [pe_ctrl_pkg::BUF_DEPTH];
  logic [pe_ctrl_pkg::BUF_PTR_W-1:0]  wr_ptr;
  logic [pe_ctrl_pkg::BUF_PTR_W-1:0]  rd_ptr;
  logic [pe_ctrl_pkg::BUF_PTR_W:0]    count;
  logic                               do_push;
  logic                               do_pop;

  assign empty    = (count == '0);
  assign full     = (count == (pe_ctrl_pkg::BUF_PTR_W + 1)'(pe_ctrl_pkg::BUF_DEPTH));
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the fetcher drops beats itself, the feeder only pops valid words
  assert property (@(posedge CLK) disable iff (!RESETN) push |-> !full);
  assert property (@(posedge CLK) disable iff (!RESETN) pop |-> !empty);

endmodule

//--- rtl/array_feeder.sv
// Array feeder
// streams weight words on load, activation bytes and psum words during a run
`timescale 1ns/100ps

module array_feeder (
  input  logic                             CLK,
  input  logic                             RESETN,
  input  logic                             start_cmd,
  input  logic                             load_cmd,
  input  pe_ctrl_pkg::dim_t                param_r,
  input  pe_ctrl_pkg::dim_t                tile_size,
  input  logic [pe_ctrl_pkg::NUM_BUFS-1:0] buf_empty,
  input  pe_ctrl_pkg::word_t               weight_word,
  input  pe_ctrl_pkg::word_t               input_word,
  input  pe_ctrl_pkg::word_t               psum_word,
  output logic [pe_ctrl_pkg::NUM_BUFS-1:0] pop,
  output pe_ctrl_pkg::word_t               weight_data,
  output logic                             weight_valid,
  output pe_ctrl_pkg::act_t                act_data,
  output logic                             act_valid,
  output pe_ctrl_pkg::word_t               psum_data,
  output logic                             psum_valid,
  output logic                             stall,
  output logic                             running
);

  pe_ctrl_pkg::feed_state_t state;
  logic [1:0]               byte_idx;
  pe_ctrl_pkg::count_t      byte_cnt;
  pe_ctrl_pkg::count_t      run_len;
  pe_ctrl_pkg::count_t      start_len;
  logic                     last_byte;

  assign start_len    = pe_ctrl_pkg::count_t'(tile_size) * pe_ctrl_pkg::count_t'(param_r);
  assign running      = (state == pe_ctrl_pkg::FEED_RUN);
  assign weight_valid = (state == pe_ctrl_pkg::FEED_WEIGHTS) && !buf_empty[pe_ctrl_pkg::BUF_WEIGHT];
  assign weight_data  = weight_word;
  assign act_valid    = running && !buf_empty[pe_ctrl_pkg::BUF_INPUT];
  assign act_data     = input_word[byte_idx*8 +: 8];
  assign psum_valid   = running && !buf_empty[pe_ctrl_pkg::BUF_PSUM];
  assign psum_data    = psum_word;
  assign stall        = running && !act_valid;
  assign last_byte    = (byte_cnt == run_len - 1'b1);

  // input word goes after its top byte or the run's last byte
  always_comb begin
    pop[pe_ctrl_pkg::BUF_WEIGHT] = weight_valid;
    pop[pe_ctrl_pkg::BUF_INPUT]  = act_valid &&
      (byte_idx == 2'(pe_ctrl_pkg::BYTES_PER_WORD - 1) || last_byte);
    pop[pe_ctrl_pkg::BUF_PSUM]   = psum_valid;
  end

  always_ff @(posedge CLK) begin
    if (state == pe_ctrl_pkg::FEED_IDLE && start_cmd) begin
      run_len <= start_len;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state    <= pe_ctrl_pkg::FEED_IDLE;
      byte_idx <= '0;
      byte_cnt <= '0;
    end else begin
      case (state)
        pe_ctrl_pkg::FEED_IDLE: begin
          byte_idx <= '0;
          byte_cnt <= '0;
          if (load_cmd) begin
            state <= pe_ctrl_pkg::FEED_WEIGHTS;
          end else if (start_cmd && start_len != '0) begin
            state <= pe_ctrl_pkg::FEED_RUN;
          end
        end
        pe_ctrl_pkg::FEED_WEIGHTS: begin
          if (buf_empty[pe_ctrl_pkg::BUF_WEIGHT]) begin
            state <= pe_ctrl_pkg::FEED_IDLE;
          end
        end
        pe_ctrl_pkg::FEED_RUN: begin
          // counters hold while the input buffer is dry
          if (act_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            byte_idx <= pop[pe_ctrl_pkg::BUF_INPUT] ? 2'd0 : byte_idx + 1'b1;
            if (last_byte) begin
              state <= pe_ctrl_pkg::FEED_IDLE;
            end
          end
        end
        default: state <= pe_ctrl_pkg::FEED_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/pe_ctrl_top.sv
// PE array control unit top
// APB registers, read burst fetcher, three operand buffers and the array feeder
`timescale 1ns/100ps

module pe_ctrl_top (
  input  logic               CLK,
  input  logic               RESETN,
  input  pe_ctrl_pkg::addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  pe_ctrl_pkg::word_t pwdata,
  output pe_ctrl_pkg::word_t prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               rd_start,
  output pe_ctrl_pkg::addr_t rd_addr,
  input  logic               rd_beat_valid,
  input  pe_ctrl_pkg::word_t rd_data,
  input  logic               rd_done,
  input  logic               rd_error,
  output pe_ctrl_pkg::word_t weight_data,
  output logic               weight_valid,
  output pe_ctrl_pkg::act_t  act_data,
  output logic               act_valid,
  output pe_ctrl_pkg::word_t psum_data,
  output logic               psum_valid,
  output logic               stall,
  output logic               running
);

  logic [pe_ctrl_pkg::NUM_BUFS-1:0] fetch_cmd;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] clear_cmd;
  logic                             start_cmd;
  logic                             load_cmd;
  pe_ctrl_pkg::addr_t               weight_base;
  pe_ctrl_pkg::addr_t               input_base;
  pe_ctrl_pkg::addr_t               psum_base;
  pe_ctrl_pkg::dim_t                param_r;
  pe_ctrl_pkg::dim_t                tile_size;
  pe_ctrl_pkg::word_t               status;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] push;
  pe_ctrl_pkg::word_t               push_data;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] pop;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] buf_full;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] buf_empty;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] buffered;
  logic [pe_ctrl_pkg::NUM_BUFS-1:0] fetch_error;
  pe_ctrl_pkg::word_t               buf_data [pe_ctrl_pkg::NUM_BUFS];

  always_comb begin
    status = '0;
    status[pe_ctrl_pkg::STAT_BUFFERED +: pe_ctrl_pkg::NUM_BUFS] = buffered;
    status[pe_ctrl_pkg::STAT_RUNNING] = running;
    status[pe_ctrl_pkg::STAT_ERROR +: pe_ctrl_pkg::NUM_BUFS] = fetch_error;
  end

  pe_ctrl_regs u_regs (
    .CLK(CLK), .RESETN(RESETN),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .status(status), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .fetch_cmd(fetch_cmd), .clear_cmd(clear_cmd), .start_cmd(start_cmd), .load_cmd(load_cmd),
    .weight_base(weight_base), .input_base(input_base), .psum_base(psum_base),
    .param_r(param_r), .tile_size(tile_size)
  );

  burst_fetcher u_fetcher (
    .CLK(CLK), .RESETN(RESETN), .fetch_cmd(fetch_cmd),
    .weight_base(weight_base), .input_base(input_base), .psum_base(psum_base),
    .buf_full(buf_full), .rd_beat_valid(rd_beat_valid), .rd_data(rd_data),
    .rd_done(rd_done), .rd_error(rd_error), .rd_start(rd_start), .rd_addr(rd_addr),
    .push(push), .push_data(push_data), .buffered(buffered), .fetch_error(fetch_error)
  );

  // one buffer per operand kind, indexed by BUF_WEIGHT, BUF_INPUT, BUF_PSUM
  for (genvar i = 0; i < pe_ctrl_pkg::NUM_BUFS; i++) begin : g_buf
    operand_buffer u_buf (
      .CLK(CLK), .RESETN(RESETN), .clear(clear_cmd[i]),
      .push(push[i]), .push_data(push_data), .pop(pop[i]),
      .pop_data(buf_data[i]), .empty(buf_empty[i]), .full(buf_full[i])
    );
  end

  array_feeder u_feeder (
    .CLK(CLK), .RESETN(RESETN), .start_cmd(start_cmd), .load_cmd(load_cmd),
    .param_r(param_r), .tile_size(tile_size), .buf_empty(buf_empty),
    .weight_word(buf_data[pe_ctrl_pkg::BUF_WEIGHT]),
    .input_word(buf_data[pe_ctrl_pkg::BUF_INPUT]),
    .psum_word(buf_data[pe_ctrl_pkg::BUF_PSUM]),
    .pop(pop), .weight_data(weight_data), .weight_valid(weight_valid),
    .act_data(act_data), .act_valid(act_valid), .psum_data(psum_data),
    .psum_valid(psum_valid), .stall(stall), .running(running)
  );

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock and reset
// 4 ns clock, active-low reset held for the first five cycles
`timescale 1ns/100ps

module tb_clock_gen (
  output logic CLK,
  output logic RESETN
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    RESETN <= 1'b0;
    repeat (5) @(posedge CLK);
    RESETN <= 1'b1;
  end

endmodule

//--- dv/pe_ctrl_tb.sv
// Testbench for the PE array control unit
// memory read model, APB access tasks and directed tests
`timescale 1ns/100ps

module pe_ctrl_tb;

  localparam int MEM_WORDS      = 1024;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam pe_ctrl_pkg::addr_t WEIGHT_BASE = 32'h100;
  localparam pe_ctrl_pkg::addr_t INPUT_BASE  = 32'h200;
  localparam pe_ctrl_pkg::addr_t PSUM_BASE   = 32'h400;

  logic               CLK;
  logic               RESETN;
  pe_ctrl_pkg::addr_t paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  pe_ctrl_pkg::word_t pwdata;
  pe_ctrl_pkg::word_t prdata;
  logic               pready;
  logic               pslverr;
  logic               rd_start;
  pe_ctrl_pkg::addr_t rd_addr;
  logic               rd_beat_valid;
  pe_ctrl_pkg::word_t rd_data;
  logic               rd_done;
  logic               rd_error;
  pe_ctrl_pkg::word_t weight_data;
  logic               weight_valid;
  pe_ctrl_pkg::act_t  act_data;
  logic               act_valid;
  pe_ctrl_pkg::word_t psum_data;
  logic               psum_valid;
  logic               stall;
  logic               running;

  pe_ctrl_pkg::word_t mem_words [MEM_WORDS];
  logic               mem_error;
  pe_ctrl_pkg::addr_t burst_q [$];
  pe_ctrl_pkg::word_t weight_q [$];
  pe_ctrl_pkg::act_t  act_q [$];
  pe_ctrl_pkg::word_t psum_q [$];
  int                 cycle_count = 0;
  integer             seed = 32'hc0550211;

  tb_clock_gen u_clk (.CLK(CLK), .RESETN(RESETN));

  pe_ctrl_top uut (
    .CLK(CLK), .RESETN(RESETN),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .rd_start(rd_start), .rd_addr(rd_addr), .rd_beat_valid(rd_beat_valid),
    .rd_data(rd_data), .rd_done(rd_done), .rd_error(rd_error),
    .weight_data(weight_data), .weight_valid(weight_valid),
    .act_data(act_data), .act_valid(act_valid),
    .psum_data(psum_data), .psum_valid(psum_valid),
    .stall(stall), .running(running)
  );

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  function automatic pe_ctrl_pkg::word_t mem_at(input pe_ctrl_pkg::addr_t byte_addr);
    return mem_words[byte_addr[11:2]];
  endfunction

  // byte i of the input stream, low byte of each word first
  function automatic pe_ctrl_pkg::act_t input_byte(input int i);
    pe_ctrl_pkg::word_t w;
    w = mem_at(INPUT_BASE + 32'(4 * (i / 4)));
    return pe_ctrl_pkg::act_t'(w >> (8 * (i % 4)));
  endfunction

  function automatic pe_ctrl_pkg::word_t cmd_bit(input int bit_pos);
    return pe_ctrl_pkg::word_t'(1) << bit_pos;
  endfunction

  task automatic apb_write(input pe_ctrl_pkg::addr_t addr, input pe_ctrl_pkg::word_t data);
    @(posedge CLK);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge CLK);
    penable <= 1'b1;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input pe_ctrl_pkg::addr_t addr, output pe_ctrl_pkg::word_t data,
                          output logic err);
    @(posedge CLK);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge CLK);
    penable <= 1'b1;
    // access phase
    @(negedge CLK);
    data = prdata;
    err  = pslverr;
    check_value("pready", 32'(pready), 1);
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_command(input pe_ctrl_pkg::word_t cmd);
    apb_write(pe_ctrl_pkg::REG_MEM_CTRL, cmd);
  endtask

  task automatic wait_status(input pe_ctrl_pkg::word_t mask);
    pe_ctrl_pkg::word_t data;
    logic               err;
    data = '0;
    while ((data & mask) != mask) begin
      apb_read(pe_ctrl_pkg::REG_STATUS, data, err);
    end
  endtask

  task automatic run_to_end();
    send_command(cmd_bit(pe_ctrl_pkg::CMD_START));
    while (!running) @(negedge CLK);
    while (running) @(negedge CLK);
  endtask

  task automatic test_registers();
    pe_ctrl_pkg::word_t data;
    logic               err;
    @(negedge CLK);
    check_value("rd_start", 32'(rd_start), 0);
    check_value("weight_valid", 32'(weight_valid), 0);
    check_value("act_valid", 32'(act_valid), 0);
    check_value("psum_valid", 32'(psum_valid), 0);
    check_value("stall", 32'(stall), 0);
    check_value("pslverr", 32'(pslverr), 0);
    apb_read(pe_ctrl_pkg::REG_STATUS, data, err);
    check_value("status", data, 0);
    check_value("pslverr", 32'(err), 0);
    apb_write(pe_ctrl_pkg::REG_ACC_PARAMS, 32'h0000_00a5);
    apb_read(pe_ctrl_pkg::REG_ACC_PARAMS, data, err);
    check_value("acc_params", data, 32'h0000_00a5);
    apb_write(pe_ctrl_pkg::REG_WEIGHT_BASE, WEIGHT_BASE);
    apb_write(pe_ctrl_pkg::REG_INPUT_BASE, INPUT_BASE);
    apb_write(pe_ctrl_pkg::REG_PSUM_BASE, PSUM_BASE);
    apb_read(pe_ctrl_pkg::REG_WEIGHT_BASE, data, err);
    check_value("weight_base", data, WEIGHT_BASE);
    apb_read(pe_ctrl_pkg::REG_INPUT_BASE, data, err);
    check_value("input_base", data, INPUT_BASE);
    apb_read(pe_ctrl_pkg::REG_PSUM_BASE, data, err);
    check_value("psum_base", data, PSUM_BASE);
    // upper bits carry no command
    apb_write(pe_ctrl_pkg::REG_MEM_CTRL, 32'hffff_ff00);
    apb_read(pe_ctrl_pkg::REG_MEM_CTRL, data, err);
    check_value("mem_ctrl", data, 0);
    apb_read(32'h18, data, err);
    check_value("pslverr", 32'(err), 1);
  endtask

  task automatic test_weight_load();
    pe_ctrl_pkg::word_t data;
    logic               err;
    burst_q.delete();
    send_command(cmd_bit(pe_ctrl_pkg::CMD_FETCH_WEIGHTS));
    wait_status(32'h1);
    check_value("weight burst count", 32'(burst_q.size()), 1);
    check_value("rd_addr", burst_q[0], WEIGHT_BASE);
    apb_read(pe_ctrl_pkg::REG_STATUS, data, err);
    check_value("status", data, 32'h1);
    weight_q.delete();
    send_command(cmd_bit(pe_ctrl_pkg::CMD_LOAD_WEIGHTS));
    while (weight_q.size() < pe_ctrl_pkg::BURST_LEN) @(negedge CLK);
    @(negedge CLK);
    check_value("weight_valid", 32'(weight_valid), 0);
    check_value("weight word count", 32'(weight_q.size()), pe_ctrl_pkg::BURST_LEN);
    for (int k = 0; k < pe_ctrl_pkg::BURST_LEN; k++) begin
      check_value("weight_data", weight_q[k], mem_at(WEIGHT_BASE + 32'(4 * k)));
    end
  endtask

  task automatic test_input_run();
    pe_ctrl_pkg::word_t data;
    pe_ctrl_pkg::addr_t expected;
    logic               err;
    apb_write(pe_ctrl_pkg::REG_ACC_PARAMS, 32'h42);
    burst_q.delete();
    send_command(cmd_bit(pe_ctrl_pkg::CMD_FETCH_INPUTS) | cmd_bit(pe_ctrl_pkg::CMD_FETCH_PSUMS));
    wait_status(32'h6);
    check_value("burst count", 32'(burst_q.size()), 5);
    for (int k = 0; k < 5; k++) begin
      if (k < 2) begin
        expected = INPUT_BASE + 32'(pe_ctrl_pkg::BURST_BYTES * k);
      end else begin
        expected = PSUM_BASE + 32'(pe_ctrl_pkg::BURST_BYTES * (k - 2));
      end
      check_value("rd_addr", burst_q[k], expected);
    end
    apb_read(pe_ctrl_pkg::REG_STATUS, data, err);
    check_value("status", data, 32'h7);
    act_q.delete();
    psum_q.delete();
    run_to_end();
    check_value("act byte count", 32'(act_q.size()), 8);
    for (int i = 0; i < 8; i++) begin
      check_value("act_data", 32'(act_q[i]), 32'(input_byte(i)));
    end
    // one psum per running cycle, buffer never runs dry here
    check_value("psum word count", 32'(psum_q.size()), 8);
    for (int k = 0; k < 8; k++) begin
      check_value("psum_data", psum_q[k], mem_at(PSUM_BASE + 32'(4 * k)));
    end
    apb_read(pe_ctrl_pkg::REG_STATUS, data, err);
    check_value("status running", 32'(data[pe_ctrl_pkg::STAT_RUNNING]), 0);
  endtask

  task automatic test_bus_error();
    pe_ctrl_pkg::word_t data;
    logic               err;
    send_command(cmd_bit(pe_ctrl_pkg::CMD_CLEAR_PSUMS));
    burst_q.delete();
    mem_error = 1'b1;
    send_command(cmd_bit(pe_ctrl_pkg::CMD_FETCH_PSUMS));
    wait_status(32'h4);
    mem_error = 1'b0;
    check_value("psum burst count", 32'(burst_q.size()), pe_ctrl_pkg::PSUM_BURSTS);
    apb_read(pe_ctrl_pkg::REG_STATUS, data, err);
    check_value("status psum error", 32'(data[pe_ctrl_pkg::STAT_ERROR + 2]), 1);
    send_command(cmd_bit(pe_ctrl_pkg::CMD_CLEAR_PSUMS));
    act_q.delete();
    psum_q.delete();
    run_to_end();
    check_value("act byte count", 32'(act_q.size()), 8);
    check_value("psum word count", 32'(psum_q.size()), 0);
  endtask

  task automatic test_random_run();
    int                 r;
    int                 tile;
    int                 len;
    pe_ctrl_pkg::addr_t a;
    for (int iter = 0; iter < 3; iter++) begin
      r    = ($random(seed) & 3) + 1;
      tile = ($random(seed) & 3) + 1;
      len  = r * tile;
      for (int k = 0; k < 32; k++) begin
        a = INPUT_BASE + 32'(4 * k);
        mem_words[a[11:2]] = $random(seed);
      end
      send_command(cmd_bit(pe_ctrl_pkg::CMD_CLEAR_INPUTS));
      send_command(cmd_bit(pe_ctrl_pkg::CMD_FETCH_INPUTS));
      wait_status(32'h2);
      apb_write(pe_ctrl_pkg::REG_ACC_PARAMS, 32'((tile << 4) | r));
      act_q.delete();
      psum_q.delete();
      run_to_end();
      check_value("act byte count", 32'(act_q.size()), 32'(len));
      for (int i = 0; i < len; i++) begin
        check_value("act_data", 32'(act_q[i]), 32'(input_byte(i)));
      end
      check_value("psum word count", 32'(psum_q.size()), 0);
    end
  endtask

  // memory read model, one burst at a time
  initial begin : memory_model
    logic [9:0] word_idx;
    rd_beat_valid <= 1'b0;
    rd_data       <= '0;
    rd_done       <= 1'b0;
    rd_error      <= 1'b0;
    forever begin
      @(posedge CLK);
      if (RESETN && rd_start) begin
        burst_q.push_back(rd_addr);
        word_idx = rd_addr[11:2];
        for (int k = 0; k < pe_ctrl_pkg::BURST_LEN; k++) begin
          rd_beat_valid <= 1'b1;
          rd_data       <= mem_words[word_idx + 10'(k)];
          @(posedge CLK);
        end
        rd_beat_valid <= 1'b0;
        rd_done       <= 1'b1;
        rd_error      <= mem_error;
        @(posedge CLK);
        rd_done  <= 1'b0;
        rd_error <= 1'b0;
      end
    end
  end

  // stream collection and the stall rule
  always @(posedge CLK) begin
    if (RESETN) begin
      if (weight_valid) begin
        weight_q.push_back(weight_data);
      end
      if (act_valid) begin
        act_q.push_back(act_data);
      end
      if (psum_valid) begin
        psum_q.push_back(psum_data);
      end
      check_value("stall", 32'(stall), 32'(running && !act_valid));
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("ERROR at %0t: tests did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    paddr     <= '0;
    psel      <= 1'b0;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    pwdata    <= '0;
    mem_error = 1'b0;
    // tag plus byte address, so every word differs
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_words[10'(i)] = 32'ha500_0000 | (32'(i) << 12) | (32'(i) << 2);
    end
    @(posedge CLK);
    while (RESETN !== 1'b1) @(posedge CLK);
    test_registers();
    test_weight_load();
    test_input_run();
    test_bus_error();
    test_random_run();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- pe_ctrl_top.f
rtl/pe_ctrl_pkg.sv
rtl/pe_ctrl_regs.sv
rtl/burst_fetcher.sv
rtl/operand_buffer.sv
rtl/array_feeder.sv
rtl/pe_ctrl_top.sv
dv/tb_clock_gen.sv
dv/pe_ctrl_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module pe_ctrl_tb \
		-f pe_ctrl_top.f -o Vpe_ctrl_tb

run: compile
	@out="$$(./obj_dir/Vpe_ctrl_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
